//--- all.f
src/snd_pkg.sv
src/chan_ctrl_if.sv
src/snd_regs.sv
src/snd_channel.sv
src/snd_mixer.sv
src/snd_chip.sv
tb/snd_checker.sv
tb/tb_snd_chip.sv

//--- run.sh
#!/bin/sh
# builds and runs the sound chip testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_snd_chip -o sim_snd_chip
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_snd_chip > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1

//--- tb/tb_snd_chip.sv
/* testbench for the sound chip, models both CPUs and the sample ROMs
   inputs change on the falling clock edge, cen is high every second clk
   only channel 0 is ever keyed on */
`timescale 1ns/1ps

module tb_snd_chip;
    import snd_pkg::*;

    // step period is at most 8 cen, so 16 clk
    localparam int max_len     = 16;
    localparam int max_period  = 16;
    localparam int cycle_limit = 4 * (2 * max_len + 4) * max_period + 3000;

    logic       clk = 1'b0;
    logic       cen = 1'b0;
    logic       rst, ma0, mrdnw, mcs, wr_n, rd_n, cs, const_en, sample;
    logic [7:0] mdout, mdin, din, dout, const_byte;
    logic [7:0] roma_data, romb_data, romc_data, romd_data;
    logic       roma_cs, romb_cs, romc_cs, romd_cs;
    reg_addr_t  addr;
    rom_addr_t  roma_addr, romb_addr, romc_addr, romd_addr;
    sample_t    aux_l, aux_r, snd_l, snd_r;
    int         seed = 32'h24608b99;
    int         cycles = 0;

    // ROM contents depend on every address bit
    function automatic logic [7:0] rom_byte(input rom_addr_t a, input logic [7:0] salt);
        return a[7:0] ^ a[15:8] ^ {a[20:16], 3'b000} ^ salt;
    endfunction

    assign roma_data = const_en ? const_byte : rom_byte(roma_addr, 8'h5A);
    assign romb_data = rom_byte(romb_addr, 8'h3C);
    assign romc_data = rom_byte(romc_addr, 8'hC3);
    assign romd_data = rom_byte(romd_addr, 8'hA5);

    snd_chip snd_chip_i (
        .clk(clk), .rst(rst), .cen(cen),
        .ma0(ma0), .mrdnw(mrdnw), .mcs(mcs), .mdout(mdout), .mdin(mdin),
        .addr(addr), .wr_n(wr_n), .rd_n(rd_n), .cs(cs), .din(din), .dout(dout),
        .roma_addr(roma_addr), .roma_data(roma_data), .roma_cs(roma_cs),
        .romb_addr(romb_addr), .romb_data(romb_data), .romb_cs(romb_cs),
        .romc_addr(romc_addr), .romc_data(romc_data), .romc_cs(romc_cs),
        .romd_addr(romd_addr), .romd_data(romd_data), .romd_cs(romd_cs),
        .aux_l(aux_l), .aux_r(aux_r), .snd_l(snd_l), .snd_r(snd_r), .sample(sample)
    );

    snd_checker chk (.clk(clk), .roma_addr(roma_addr), .sample(sample));

    always #20 clk = ~clk;

    always @(negedge clk) cen <= ~cen;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, a test did not finish", cycles);
            chk.report();
            $display("tests failed");
            $finish;
        end
    end

    // all bus tasks start and end on a falling edge
    task automatic sound_write(input reg_addr_t a, input logic [7:0] d);
        addr = a;
        din  = d;
        cs   = 1'b1;
        wr_n = 1'b0;
        @(negedge clk);
        cs   = 1'b0;
        wr_n = 1'b1;
    endtask

    task automatic sound_read(input reg_addr_t a, output logic [7:0] d);
        addr = a;
        cs   = 1'b1;
        rd_n = 1'b0;
        @(negedge clk);
        d    = dout;
        cs   = 1'b0;
        rd_n = 1'b1;
        // idle cycle lets a test read advance the ROM address
        @(negedge clk);
    endtask

    task automatic main_write(input logic sel, input logic [7:0] d);
        ma0   = sel;
        mdout = d;
        mrdnw = 1'b0;
        mcs   = 1'b1;
        @(negedge clk);
        mcs   = 1'b0;
        mrdnw = 1'b1;
    endtask

    task automatic main_read(input logic sel, output logic [7:0] d);
        ma0   = sel;
        mrdnw = 1'b1;
        mcs   = 1'b1;
        @(negedge clk);
        d     = mdin;
        mcs   = 1'b0;
    endtask

    // channels 1 to 3 are never programmed and wait at address 1
    task automatic rom_port_check(input logic a_cs);
        chk.compare("rom a cs", int'(a_cs), int'(roma_cs));
        chk.compare("rom b cs", 0, int'(romb_cs));
        chk.compare("rom c cs", 0, int'(romc_cs));
        chk.compare("rom d cs", 0, int'(romd_cs));
        chk.compare("rom b addr", 1, int'(romb_addr));
        chk.compare("rom c addr", 1, int'(romc_addr));
        chk.compare("rom d addr", 1, int'(romd_addr));
    endtask

    task automatic program_ch0(input rom_addr_t st, input logic [15:0] len,
                               input logic [11:0] pit, input logic [6:0] vol);
        sound_write(6'd8, pit[7:0]);
        sound_write(6'd9, {4'd0, pit[11:8]});
        sound_write(6'd10, len[7:0]);
        sound_write(6'd11, len[15:8]);
        sound_write(6'd12, st[7:0]);
        sound_write(6'd13, st[15:8]);
        sound_write(6'd14, {3'd0, st[20:16]});
        sound_write(6'd15, {1'b0, vol});
    endtask

    task automatic latch_test();
        int         r;
        logic [7:0] v;
        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            main_write(i[0], r[7:0]);
            sound_read(6'(i % 2), v);
            chk.compare("latch main to sound", int'(r[7:0]), int'(v));
            sound_write(addr_latch_lo + 6'(i % 2), r[15:8]);
            main_read(i[0], v);
            chk.compare("latch sound to main", int'(r[15:8]), int'(v));
        end
    endtask

    task automatic play_test(input logic adpcm, input logic lp, input string name);
        int          r;
        int          want;
        rom_addr_t   st;
        logic [15:0] len;
        logic [11:0] pit;
        logic [7:0]  v;
        r    = $random(seed);
        st   = r[20:0];
        len  = {12'd0, r[24:21]};
        pit  = 12'd4088 + {9'd0, r[27:25]};
        want = adpcm ? 2 * (int'(len) + 1) : int'(len) + 1;
        program_ch0(st, len, pit, 7'd64);
        sound_write(addr_loop_adpcm, {3'd0, adpcm, 3'd0, lp});
        chk.set_test(name);
        chk.arm(st, int'(len), lp, adpcm);
        sound_write(addr_keyon, 8'h01);
        repeat (4) @(negedge clk);
        rom_port_check(1'b1);
        if (lp) begin
            // run past the wrap into a second pass
            while (chk.pulses < want + 2) @(negedge clk);
            sound_read(addr_status, v);
            chk.compare({name, " bsy"}, 1, int'(v[0]));
        end else begin
            v = 8'h01;
            while (v[0]) sound_read(addr_status, v);
            chk.compare({name, " pulses"}, want, chk.pulses);
        end
        chk.disarm();
        sound_write(addr_keyon, 8'h00);
        repeat (4) @(negedge clk);
        rom_port_check(1'b0);
    endtask

    task automatic test_read_test();
        int         r;
        rom_addr_t  st;
        logic [7:0] v;
        r  = $random(seed);
        st = r[20:0];
        program_ch0(st, 16'd4, 12'd4095, 7'd0);
        sound_write(addr_mode, 8'h01);
        repeat (3) @(negedge clk);
        rom_port_check(1'b1);
        for (int i = 0; i < 8; i++) begin
            sound_read(addr_test_rd, v);
            chk.compare("test read", int'(rom_byte(st + 21'(i), 8'h5A)), int'(v));
        end
        sound_write(addr_mode, 8'h00);
    endtask

    task automatic output_test();
        int         r;
        int         e;
        logic [7:0] b;
        r          = $random(seed);
        // positive byte so the key-off decay settles at zero
        b          = {1'b0, r[6:0]};
        const_byte = b;
        const_en   = 1'b1;
        program_ch0(r[28:8], 16'd8, 12'd4095, 7'd127);
        sound_write(addr_pan01, 8'h01);
        sound_write(addr_loop_adpcm, 8'h01);
        sound_write(addr_mode, 8'h02);
        sound_write(addr_keyon, 8'h01);
        repeat (20) @(negedge clk);
        e = chk.chan_out(int'(b), 127, 1);
        chk.compare("channel out left", e, int'(snd_l));
        chk.compare("channel out right", 0, int'(snd_r));
        // a large aux value on top of the channel can push the sum into clipping
        r     = $random(seed);
        aux_l = {2'b01, r[13:0]};
        repeat (4) @(negedge clk);
        chk.compare("mixer saturation", chk.sat16(e + int'(aux_l)), int'(snd_l));
        sound_write(addr_keyon, 8'h00);
        repeat (24) @(negedge clk);
        const_en = 1'b0;
    endtask

    task automatic mixer_test();
        int   r;
        int   k;
        int   el;
        int   er;
        logic c;
        sound_write(addr_mode, 8'h02);
        for (int i = 0; i < 6; i++) begin
            r     = $random(seed);
            aux_l = r[15:0];
            aux_r = r[31:16];
            repeat (4) @(negedge clk);
            chk.compare("mixer left", chk.sat16(int'(aux_l)), int'(snd_l));
            chk.compare("mixer right", chk.sat16(int'(aux_r)), int'(snd_r));
        end
        el = chk.sat16(int'(aux_l));
        er = chk.sat16(int'(aux_r));
        sound_write(addr_mode, 8'h00);
        k = 0;
        while (k < 5) begin
            @(posedge clk);
            c = cen;
            @(negedge clk);
            if (c) begin
                k++;
                chk.compare("fade left", el >>> k, int'(snd_l));
                chk.compare("fade right", er >>> k, int'(snd_r));
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        ma0        = 1'b0;
        mrdnw      = 1'b1;
        mcs        = 1'b0;
        mdout      = 8'd0;
        addr       = '0;
        wr_n       = 1'b1;
        rd_n       = 1'b1;
        cs         = 1'b0;
        din        = 8'd0;
        aux_l      = '0;
        aux_r      = '0;
        const_en   = 1'b0;
        const_byte = 8'd0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        rom_port_check(1'b0);
        latch_test();
        play_test(1'b0, 1'b0, "pcm sequence");
        play_test(1'b1, 1'b0, "adpcm sequence");
        play_test(1'b0, 1'b1, "loop sequence");
        test_read_test();
        output_test();
        mixer_test();
        chk.report();
        if (chk.errors() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tb/snd_checker.sv
/* reference model and comparator for the sound chip testbench
   follows channel 0's ROM address on each sample pulse while armed
   value checks are handed in by the test sequence */
`timescale 1ns/1ps

module snd_checker (
    input  logic                clk,
    input  snd_pkg::rom_addr_t  roma_addr,
    input  logic                sample
);
    import snd_pkg::*;

    string     test_name = "idle";
    int        mism = 0;
    int        seq_err = 0;
    int        pulses = 0;
    int        cfg_len = 0;
    int        cnt = 0;
    logic      armed = 1'b0;
    logic      armed_d = 1'b0;
    logic      cfg_loop = 1'b0;
    logic      cfg_adpcm = 1'b0;
    logic      half = 1'b0;
    rom_addr_t cfg_start = '0;
    rom_addr_t exp_addr = '0;

    // left gain per pan code with code 0 off
    function automatic int gain_l(input int code);
        case (code)
            1: return 127;
            2: return 116;
            3: return 104;
            4: return 90;
            5: return 73;
            6: return 52;
            default: return 0;
        endcase
    endfunction

    // signed byte times the top bits of volume times gain
    function automatic int chan_out(input int b, input int vol, input int code);
        int s;
        s = (b > 127) ? b - 256 : b;
        return s * ((vol * gain_l(code)) / 128);
    endfunction

    function automatic int sat16(input int s);
        if (s > 32767) return 32767;
        if (s < -32768) return -32768;
        return s;
    endfunction

    function automatic int errors();
        return mism + seq_err;
    endfunction

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic arm(input rom_addr_t st, input int len, input logic lp, input logic ad);
        cfg_start = st;
        cfg_len   = len;
        cfg_loop  = lp;
        cfg_adpcm = ad;
        armed     = 1'b1;
    endtask

    task automatic disarm();
        armed = 1'b0;
    endtask

    task automatic compare(input string name, input int exp, input int act);
        if (exp !== act) begin
            mism++;
            $display("mismatch %s: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic report();
        $display("errors: %0d value mismatches, %0d address sequence errors", mism, seq_err);
    endtask

    // address model steps from start+1 once per pulse or every second pulse in ADPCM
    always @(posedge clk) begin
        if (armed && !armed_d) begin
            exp_addr = cfg_start + 21'd1;
            cnt      = cfg_len;
            half     = 1'b0;
            pulses   = 0;
        end else if (armed && sample) begin
            pulses++;
            if (roma_addr !== exp_addr) begin
                seq_err++;
                $display("mismatch %s rom_addr: expected %h actual %h",
                         test_name, exp_addr, roma_addr);
            end
            if (!cfg_adpcm || half) begin
                if (cnt == 0 && cfg_loop) begin
                    exp_addr = cfg_start;
                    cnt      = cfg_len;
                end else begin
                    exp_addr = exp_addr + 21'd1;
                    cnt--;
                end
            end
            half = !half;
        end
        armed_d = armed;
    end

endmodule

//--- src/snd_chip.sv
/* four-channel PCM/ADPCM sound chip with main CPU message latches
   ROMs and both CPUs are external and always ready
   cen is a clock-enable pulse that paces pitch counters and the mixer */
`timescale 1ns/1ps

module snd_chip (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    // main CPU
    input  logic                ma0,
    input  logic                mrdnw,
    input  logic                mcs,
    input  logic [7:0]          mdout,
    output logic [7:0]          mdin,
    // sound CPU
    input  snd_pkg::reg_addr_t  addr,
    input  logic                wr_n,
    input  logic                rd_n,
    input  logic                cs,
    input  logic [7:0]          din,
    output logic [7:0]          dout,
    // sample ROMs, one per channel
    output snd_pkg::rom_addr_t  roma_addr,
    input  logic [7:0]          roma_data,
    output logic                roma_cs,
    output snd_pkg::rom_addr_t  romb_addr,
    input  logic [7:0]          romb_data,
    output logic                romb_cs,
    output snd_pkg::rom_addr_t  romc_addr,
    input  logic [7:0]          romc_data,
    output logic                romc_cs,
    output snd_pkg::rom_addr_t  romd_addr,
    input  logic [7:0]          romd_data,
    output logic                romd_cs,
    // audio
    input  snd_pkg::sample_t    aux_l,
    input  snd_pkg::sample_t    aux_r,
    output snd_pkg::sample_t    snd_l,
    output snd_pkg::sample_t    snd_r,
    output logic                sample
);
    import snd_pkg::*;

    rom_addr_t               rom_addr [num_channels];
    logic [7:0]              rom_data [num_channels];
    logic [num_channels-1:0] rom_cs, ch_sample;
    sample_t                 ch_l [num_channels];
    sample_t                 ch_r [num_channels];
    logic                    out_en;

    chan_ctrl_if ctrl [num_channels] ();

    assign roma_addr   = rom_addr[0];
    assign romb_addr   = rom_addr[1];
    assign romc_addr   = rom_addr[2];
    assign romd_addr   = rom_addr[3];
    assign {romd_cs, romc_cs, romb_cs, roma_cs} = rom_cs;
    assign rom_data[0] = roma_data;
    assign rom_data[1] = romb_data;
    assign rom_data[2] = romc_data;
    assign rom_data[3] = romd_data;
    assign sample      = |ch_sample;

    snd_regs u_regs (
        .clk(clk), .rst(rst), .cen(cen),
        .ma0(ma0), .mrdnw(mrdnw), .mcs(mcs), .mdout(mdout), .mdin(mdin),
        .addr(addr), .wr_n(wr_n), .rd_n(rd_n), .cs(cs), .din(din), .dout(dout),
        .test_data(roma_data), .out_en(out_en),
        .chan0(ctrl[0]), .chan1(ctrl[1]), .chan2(ctrl[2]), .chan3(ctrl[3])
    );

    for (genvar i = 0; i < num_channels; i++) begin : g_chan
        snd_channel u_chan (
            .clk(clk), .rst(rst), .cen(cen),
            .rom_data(rom_data[i]),
            .ctrl(ctrl[i]),
            .rom_addr(rom_addr[i]), .rom_cs(rom_cs[i]),
            .snd_l(ch_l[i]), .snd_r(ch_r[i]), .sample(ch_sample[i])
        );
    end

    snd_mixer u_mixer (
        .clk(clk), .rst(rst), .cen(cen), .out_en(out_en),
        .ch_l(ch_l), .ch_r(ch_r), .aux_l(aux_l), .aux_r(aux_r),
        .snd_l(snd_l), .snd_r(snd_r)
    );

endmodule

//--- src/snd_mixer.sv
/* five-input stereo mixer, four channels plus the auxiliary input
   the sum is taken on cen and clipped to 16 bits, no peak detection
   with out_en low the outputs fade to zero by halving on each cen */
`timescale 1ns/1ps

module snd_mixer (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              out_en,
    input  snd_pkg::sample_t  ch_l [snd_pkg::num_channels],
    input  snd_pkg::sample_t  ch_r [snd_pkg::num_channels],
    input  snd_pkg::sample_t  aux_l,
    input  snd_pkg::sample_t  aux_r,
    output snd_pkg::sample_t  snd_l,
    output snd_pkg::sample_t  snd_r
);
    import snd_pkg::*;

    logic signed [18:0] sum_l, sum_r;

    function automatic logic signed [18:0] add5(input sample_t ch [num_channels],
                                                 input sample_t aux);
        logic signed [18:0] acc;
        acc = 19'(aux);
        for (int i = 0; i < num_channels; i++) begin
            acc = acc + 19'(ch[i]);
        end
        return acc;
    endfunction

    function automatic sample_t sat(input logic signed [18:0] s);
        if (s > 19'sd32767) return 16'sh7FFF;
        if (s < -19'sd32768) return 16'sh8000;
        return s[15:0];
    endfunction

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sum_l <= '0;
            sum_r <= '0;
        end else if (cen) begin
            sum_l <= add5(ch_l, aux_l);
            sum_r <= add5(ch_r, aux_r);
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            snd_l <= '0;
            snd_r <= '0;
        end else if (out_en) begin
            snd_l <= sat(sum_l);
            snd_r <= sat(sum_r);
        end else if (cen) begin
            snd_l <= snd_l >>> 1;
            snd_r <= snd_r >>> 1;
        end
    end

endmodule

//--- src/snd_channel.sv
/* one sample playback channel
   ROM data must be valid one clk after rom_addr changes
   the first ROM byte of a sample is skipped, playback starts at start+1
   loop restarts at start itself, so that byte is played on later passes */
`timescale 1ns/1ps

module snd_channel (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic [7:0]          rom_data,
    chan_ctrl_if.chan           ctrl,
    output snd_pkg::rom_addr_t  rom_addr,
    output logic                rom_cs,
    output snd_pkg::sample_t    snd_l,
    output snd_pkg::sample_t    snd_r,
    output logic                sample
);
    import snd_pkg::*;

    logic [7:0]        mmr [8];
    rom_addr_t         start;
    logic [15:0]       length;
    logic [11:0]       pitch;
    logic [6:0]        volume;

    logic [16:0]       cnt;
    logic [11:0]       pitch_cnt;
    logic [12:0]       nx_pitch_cnt;
    logic              adpcm_cnt, keyon_l, tst_l, step, done;
    logic [3:0]        nibble;
    logic signed [7:0] pre_snd, kadpcm, svl, svr;
    logic [13:0]       vol_l, vol_r;
    sample_t           mul_l, mul_r;

    assign pitch  = {mmr[1][3:0], mmr[0]};
    assign length = {mmr[3], mmr[2]};
    assign start  = {mmr[6][4:0], mmr[5], mmr[4]};
    assign volume = mmr[7][6:0];

    assign nx_pitch_cnt = {1'b0, pitch_cnt} + 13'd1;
    assign step         = nx_pitch_cnt[12];
    // length counter underflow ends playback
    assign done         = cnt[16];
    assign sample       = cen && ctrl.keyon && step && !done;

    // low nibble first
    assign nibble = adpcm_cnt ? rom_data[7:4] : rom_data[3:0];
    assign kadpcm = adpcm_step[nibble];

    // top 7 bits of volume times pan gain
    assign svl   = {1'b0, vol_l[13:7]};
    assign svr   = {1'b0, vol_r[13:7]};
    assign mul_l = 16'(pre_snd) * 16'(svl);
    assign mul_r = 16'(pre_snd) * 16'(svr);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) mmr[i] <= '0;
        end else if (ctrl.we) begin
            mmr[ctrl.addr] <= ctrl.din;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vol_l <= '0;
            vol_r <= '0;
            snd_l <= '0;
            snd_r <= '0;
        end else begin
            vol_l <= 14'(volume) * 14'(ctrl.pan_l);
            vol_r <= 14'(volume) * 14'(ctrl.pan_r);
            // halve on key-off so the output decays without a click
            snd_l <= ctrl.keyon ? mul_l : snd_l >>> 1;
            snd_r <= ctrl.keyon ? mul_r : snd_r >>> 1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_addr  <= '0;
            rom_cs    <= 1'b0;
            cnt       <= '0;
            pitch_cnt <= '0;
            adpcm_cnt <= 1'b0;
            pre_snd   <= '0;
            keyon_l   <= 1'b0;
            tst_l     <= 1'b0;
            ctrl.bsy  <= 1'b0;
        end else begin
            rom_cs <= 1'b1;
            tst_l  <= ctrl.tst_en;
            if (cen) keyon_l <= ctrl.keyon;
            if (!ctrl.keyon) begin
                if (!ctrl.tst_en) begin
                    rom_addr <= start + 21'd1;
                end else if (ctrl.we || !tst_l) begin
                    // test reads begin at start
                    rom_addr <= start;
                end else if (ctrl.tst_nx) begin
                    rom_addr <= rom_addr + 21'd1;
                end
                rom_cs    <= ctrl.tst_en;
                cnt       <= {1'b0, length};
                pitch_cnt <= pitch;
                adpcm_cnt <= 1'b0;
                pre_snd   <= '0;
                ctrl.bsy  <= 1'b0;
            end else if (cen) begin
                if (!keyon_l) ctrl.bsy <= 1'b1;
                if (step && !done) begin
                    adpcm_cnt <= !adpcm_cnt;
                    // ADPCM uses both nibbles before moving on
                    if (adpcm_cnt || !ctrl.adpcm_en) begin
                        if (cnt == 17'd0 && ctrl.loop) begin
                            rom_addr <= start;
                            cnt      <= {1'b0, length};
                        end else begin
                            rom_addr <= rom_addr + 21'd1;
                            cnt      <= cnt - 17'd1;
                        end
                    end
                    pre_snd <= ctrl.adpcm_en ? pre_snd + kadpcm : rom_data;
                end
                pitch_cnt <= step ? pitch : nx_pitch_cnt[11:0];
                if (done) begin
                    // decay towards zero to keep the dc level low
                    pre_snd  <= pre_snd >>> 1;
                    ctrl.bsy <= 1'b0;
                end
            end
        end
    end

endmodule

//--- src/snd_regs.sv
/* sound CPU register file and the two message latches to the main CPU
   CPU strobes are sampled on clk, writes repeat while wr_n stays low
   a test read returns channel 0's ROM byte only while mode bit 0 is set */
`timescale 1ns/1ps

module snd_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    // main CPU
    input  logic                ma0,
    input  logic                mrdnw,
    input  logic                mcs,
    input  logic [7:0]          mdout,
    output logic [7:0]          mdin,
    // sound CPU
    input  snd_pkg::reg_addr_t  addr,
    input  logic                wr_n,
    input  logic                rd_n,
    input  logic                cs,
    input  logic [7:0]          din,
    output logic [7:0]          dout,
    input  logic [7:0]          test_data,
    output logic                out_en,
    chan_ctrl_if.regs           chan0,
    chan_ctrl_if.regs           chan1,
    chan_ctrl_if.regs           chan2,
    chan_ctrl_if.regs           chan3
);
    import snd_pkg::*;

    logic [7:0]              pm2s [2];
    logic [7:0]              ps2m [2];
    logic [num_channels-1:0] keyon, loop, adpcm_en, bsy, chan_we;
    pan_code_t               pan [num_channels];
    logic [1:0]              mode;
    logic                    tst_rd, tst_rdl, wr_act, rd_act;

    assign wr_act = cs && !wr_n;
    assign rd_act = cs && !rd_n;
    assign out_en = mode[1];

    // channel n owns addresses 8*(n+1) to 8*(n+1)+7
    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            chan_we[i] = wr_act && addr[5:3] == 3'(i + 1);
        end
    end

    // main CPU side of the latches
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pm2s[0] <= '0;
            pm2s[1] <= '0;
            mdin    <= '0;
        end else if (mcs) begin
            mdin <= ps2m[ma0];
            if (!mrdnw) pm2s[ma0] <= mdout;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ps2m[0]  <= '0;
            ps2m[1]  <= '0;
            keyon    <= '0;
            loop     <= '0;
            adpcm_en <= '0;
            mode     <= '0;
            for (int i = 0; i < num_channels; i++) pan[i] <= '0;
            dout     <= '0;
            tst_rd   <= 1'b0;
            tst_rdl  <= 1'b0;
        end else begin
            tst_rdl <= tst_rd;
            tst_rd  <= rd_act && addr == addr_test_rd;
            if (wr_act) begin
                case (addr)
                    addr_latch_lo, addr_latch_lo + 6'd1: ps2m[addr[0]] <= din;
                    addr_keyon:      keyon <= din[3:0];
                    addr_loop_adpcm: {adpcm_en, loop} <= din;
                    addr_pan01:      {pan[1], pan[0]} <= din[5:0];
                    addr_pan23:      {pan[3], pan[2]} <= din[5:0];
                    addr_mode:       mode <= din[1:0];
                    default: ;
                endcase
            end
            if (rd_act) begin
                case (addr)
                    6'h00, 6'h01: dout <= pm2s[addr[0]];
                    addr_status:  dout <= {4'd0, bsy};
                    // byte is taken once, on the first cycle of the burst
                    addr_test_rd: if (!tst_rd) dout <= mode[0] ? test_data : 8'd0;
                    default:      dout <= '0;
                endcase
            end
        end
    end

    // channel 0
    assign chan0.addr     = addr[2:0];
    assign chan0.din      = din;
    assign chan0.we       = chan_we[0];
    assign chan0.keyon    = keyon[0];
    assign chan0.loop     = loop[0];
    assign chan0.adpcm_en = adpcm_en[0];
    assign chan0.pan_l    = pan_gain_l[pan[0]];
    assign chan0.pan_r    = pan_gain_r[pan[0]];
    assign chan0.tst_en   = mode[0];
    // one pulse per read burst advances the ROM address
    assign chan0.tst_nx   = tst_rd && !tst_rdl;
    assign bsy[0]         = chan0.bsy;

    // channel 1
    assign chan1.addr     = addr[2:0];
    assign chan1.din      = din;
    assign chan1.we       = chan_we[1];
    assign chan1.keyon    = keyon[1];
    assign chan1.loop     = loop[1];
    assign chan1.adpcm_en = adpcm_en[1];
    assign chan1.pan_l    = pan_gain_l[pan[1]];
    assign chan1.pan_r    = pan_gain_r[pan[1]];
    assign chan1.tst_en   = 1'b0;
    assign chan1.tst_nx   = 1'b0;
    assign bsy[1]         = chan1.bsy;

    // channel 2
    assign chan2.addr     = addr[2:0];
    assign chan2.din      = din;
    assign chan2.we       = chan_we[2];
    assign chan2.keyon    = keyon[2];
    assign chan2.loop     = loop[2];
    assign chan2.adpcm_en = adpcm_en[2];
    assign chan2.pan_l    = pan_gain_l[pan[2]];
    assign chan2.pan_r    = pan_gain_r[pan[2]];
    assign chan2.tst_en   = 1'b0;
    assign chan2.tst_nx   = 1'b0;
    assign bsy[2]         = chan2.bsy;

    // channel 3
    assign chan3.addr     = addr[2:0];
    assign chan3.din      = din;
    assign chan3.we       = chan_we[3];
    assign chan3.keyon    = keyon[3];
    assign chan3.loop     = loop[3];
    assign chan3.adpcm_en = adpcm_en[3];
    assign chan3.pan_l    = pan_gain_l[pan[3]];
    assign chan3.pan_r    = pan_gain_r[pan[3]];
    assign chan3.tst_en   = 1'b0;
    assign chan3.tst_nx   = 1'b0;
    assign bsy[3]         = chan3.bsy;

endmodule

//--- src/chan_ctrl_if.sv
/* per-channel control from the register block
   tst_en and tst_nx only matter on channel 0 */
`timescale 1ns/1ps

interface chan_ctrl_if;
    import snd_pkg::*;

    // register window write
    logic [2:0] addr;
    logic [7:0] din;
    logic       we;
    // control levels
    logic       keyon;
    logic       loop;
    logic       adpcm_en;
    pan_gain_t  pan_l;
    pan_gain_t  pan_r;
    logic       tst_en;
    logic       tst_nx;
    logic       bsy;

    modport regs (output addr, din, we, keyon, loop, adpcm_en, pan_l, pan_r,
                  tst_en, tst_nx, input bsy);
    modport chan (input addr, din, we, keyon, loop, adpcm_en, pan_l, pan_r,
                  tst_en, tst_nx, output bsy);
endinterface

//--- src/snd_pkg.sv
/* widths, sound CPU register map and lookup tables of the sound chip
   pan tables take the 3-bit pan code as index and code 0 mutes the channel
   ADPCM steps are signed deltas added to an 8-bit accumulator */
package snd_pkg;
    typedef logic        [20:0] rom_addr_t;
    typedef logic signed [15:0] sample_t;
    typedef logic        [ 6:0] pan_gain_t;
    typedef logic        [ 5:0] reg_addr_t;
    typedef logic        [ 2:0] pan_code_t;

    localparam int num_channels = 4;

    // sound CPU register map
    localparam reg_addr_t addr_latch_lo   = 6'h02;
    localparam reg_addr_t addr_keyon      = 6'h28;
    localparam reg_addr_t addr_status     = 6'h29;
    localparam reg_addr_t addr_loop_adpcm = 6'h2A;
    localparam reg_addr_t addr_pan01      = 6'h2C;
    localparam reg_addr_t addr_pan23      = 6'h2D;
    localparam reg_addr_t addr_test_rd    = 6'h2E;
    localparam reg_addr_t addr_mode       = 6'h2F;

    // 0 .. 64 then -128 .. -1
    localparam logic signed [7:0] adpcm_step [16] = '{
        8'h00, 8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40,
        8'h80, 8'hC0, 8'hE0, 8'hF0, 8'hF8, 8'hFC, 8'hFE, 8'hFF
    };

    // code 1 is full left, 4 centre, 7 full right
    localparam pan_gain_t pan_gain_l [8] = '{
        7'd0, 7'd127, 7'd116, 7'd104, 7'd90, 7'd73, 7'd52, 7'd0
    };
    localparam pan_gain_t pan_gain_r [8] = '{
        7'd0, 7'd0, 7'd52, 7'd73, 7'd90, 7'd104, 7'd116, 7'd127
    };
endpackage
